//--- build.f
src/gb_bus_pkg.sv
src/gb_isa_pkg.sv
src/gb_alu.sv
src/instr_decode.sv
src/bus_cycle_seq.sv
src/cpu_regs.sv
src/gb_cpu_top.sv
sim/gb_cpu_assert.sv
sim/tb_gb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_gb_cpu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation passed

SOURCES := $(wildcard src/*.sv sim/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_gb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gb_cpu
    import gb_isa_pkg::*;
();

    localparam int CLK_PERIOD      = 8;
    localparam int NUM_TESTS       = 15;
    localparam int PROGRAM_MCYCLES = 162 + 5;  // All programs plus the idle wait after HALT
    localparam int WATCHDOG_NS     = (PROGRAM_MCYCLES + NUM_TESTS * 4) * 4 * 2 * CLK_PERIOD;

    logic        clk;
    logic        rst;
    logic [7:0]  din;
    logic [15:0] a;
    logic [7:0]  dout;
    logic        rd;
    logic        wr;
    logic        phi;
    logic        done;

    logic [7:0]  mem [0:65535];
    logic [15:0] load_ptr;
    logic [31:0] lcg_state = 32'hc56a_249c;
    logic [15:0] rd_addrs [$];    // Address of every rd pulse
    logic [23:0] writes [$];      // {a, dout} of every wr pulse
    logic        rd_prev;
    logic        wr_prev;
    int          halt_rd_rises;
    int          tests_run;
    int          tests_failed;
    int          test_errors;
    string       test_name;

    gb_cpu_top i_gb_cpu_top (
        .clk  (clk),
        .rst  (rst),
        .din  (din),
        .a    (a),
        .dout (dout),
        .rd   (rd),
        .wr   (wr),
        .phi  (phi),
        .done (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the DUT never reached HALT", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Memory model and bus monitor
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rd) begin
            din <= mem[a];  // Valid by the T_DATA edge
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_prev <= 1'b0;
            wr_prev <= 1'b0;
        end else begin
            rd_prev <= rd;
            wr_prev <= wr;
            if (rd && !rd_prev) begin
                rd_addrs.push_back(a);
                if (done) halt_rd_rises++;
            end
            if (wr && !wr_prev) writes.push_back({a, dout});
            assert (!(rd && wr)) else begin
                $display("%s: rd and wr were high together", test_name);
                test_errors++;
            end
        end
    end

    function automatic logic [7:0] rand8();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // Returns {z, n, h, c, result}
    function automatic logic [11:0] alu_model(input logic [2:0] op, input logic [7:0] x,
                                              input logic [7:0] y, input logic [3:0] f);
        int         cin;
        int         r;
        logic [7:0] res;
        logic       z;
        logic       n;
        logic       h;
        logic       c;
        cin = 0;
        if ((op == 3'd1) || (op == 3'd3)) cin = f[0] ? 1 : 0;
        n   = 1'b0;
        h   = 1'b0;
        c   = 1'b0;
        res = x;
        r   = 0;
        case (op)
            3'd0, 3'd1: begin
                r   = int'(x) + int'(y) + cin;
                res = r[7:0];
                h   = (int'(x[3:0]) + int'(y[3:0]) + cin) > 15;
                c   = r > 255;
            end
            3'd2, 3'd3, 3'd7: begin
                r = int'(x) - int'(y) - cin;
                n = 1'b1;
                h = int'(x[3:0]) < (int'(y[3:0]) + cin);
                c = r < 0;
                if (op != 3'd7) res = r[7:0];
            end
            3'd4: begin
                res = x & y;
                h   = 1'b1;
            end
            3'd5: res = x ^ y;
            default: res = x | y;
        endcase
        z = (op == 3'd7) ? (r[7:0] == 8'h00) : (res == 8'h00);
        return {z, n, h, c, res};
    endfunction

    ////////////////////////////////////////////////////////////
    // Program loading, run and checks
    ////////////////////////////////////////////////////////////

    task automatic start_test(input string name);
        logic [15:0] addr;
        test_name   = name;
        test_errors = 0;
        load_ptr    = 16'h0000;
        addr        = 16'h0000;
        do begin
            mem[addr] = addr[15:8] ^ {addr[6:0], addr[7]} ^ 8'hA5;
            addr++;
        end while (addr != 16'h0000);
    endtask

    task automatic emit(input logic [7:0] b);
        mem[load_ptr] = b;
        load_ptr++;
    endtask

    // Opcode followed by len - 1 operand bytes, low byte first
    task automatic emit_instr(input logic [7:0] op, input int len, input logic [15:0] arg);
        emit(op);
        if (len > 1) emit(arg[7:0]);
        if (len > 2) emit(arg[15:8]);
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s: %s", test_name, msg);
            test_errors++;
        end
    endtask

    task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] act);
        assert (exp == act) else begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic run_program();
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_true((rd == 1'b0) && (wr == 1'b0) && (done == 1'b0) && (phi == 1'b1),
                   "outputs not idle during reset");
        rd_addrs.delete();
        writes.delete();
        halt_rd_rises = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_true((rd == 1'b0) && (wr == 1'b0) && (done == 1'b0) && (phi == 1'b1) &&
                   (a == 16'h0000) && (dout == 8'h00),
                   "outputs not idle right after reset");
        while (done !== 1'b1) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic check_write(input logic [15:0] exp_addr, input logic [7:0] exp_data);
        if (writes.size() != 1) begin
            check_true(1'b0, $sformatf("expected one write, saw %0d", writes.size()));
        end else begin
            check_value("write address", exp_addr, writes[0][23:8]);
            check_value("write data", {8'h00, exp_data}, {8'h00, writes[0][7:0]});
        end
    endtask

    function automatic logic was_fetched(input logic [15:0] addr);
        foreach (rd_addrs[i]) begin
            if (rd_addrs[i] == addr) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", test_name, test_errors);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    initial begin
        logic [7:0]  x;
        logic [7:0]  y;
        logic [7:0]  p;
        logic [11:0] m;
        logic [15:0] target;
        logic        taken;
        string       alu_names [8] = '{"alu_add", "alu_adc", "alu_sub", "alu_sbc",
                                       "alu_and", "alu_xor", "alu_or", "alu_cp"};
        string       cc_names [4]  = '{"jp_nz", "jp_z", "jp_nc", "jp_c"};
        logic [7:0]  cc_ops [4]    = '{OP_JP_NZ, OP_JP_Z, OP_JP_NC, OP_JP_C};
        rst          = 1'b1;
        din          = 8'h00;
        tests_run    = 0;
        tests_failed = 0;

        start_test("reset");
        emit(OP_NOP);
        emit(OP_HALT);
        run_program();
        check_true(rd_addrs.size() > 0, "no read strobe after reset");
        if (rd_addrs.size() > 0) check_value("first rd address", 16'h0000, rd_addrs[0]);
        finish_test();

        start_test("load_store");
        x = rand8();
        p = rand8();
        emit_instr(OP_LD_A_D8, 2, {8'h00, x});
        emit_instr(OP_LDH_A8_A, 2, {8'h00, p});
        emit(OP_HALT);
        run_program();
        check_write({8'hFF, p}, x);
        finish_test();

        for (int op = 0; op < 8; op++) begin
            start_test(alu_names[op]);
            x = rand8();
            y = rand8();
            m = alu_model(3'd0, x, y, 4'h0);  // Leading ADD sets a random carry
            emit_instr(OP_LD_A_D8, 2, {8'h00, x});
            emit_instr(OP_ALU_D8_MATCH, 2, {8'h00, y});
            x = rand8();
            y = rand8();
            p = rand8();
            m = alu_model(3'(op), x, y, m[11:8]);
            emit_instr(OP_LD_A_D8, 2, {8'h00, x});
            emit_instr(OP_ALU_D8_MATCH | {2'b00, 3'(op), 3'b000}, 2, {8'h00, y});
            emit_instr(OP_LDH_A8_A, 2, {8'h00, p});
            emit(OP_HALT);
            run_program();
            check_write({8'hFF, p}, m[7:0]);
            finish_test();
        end

        for (int cc = 0; cc < 4; cc++) begin
            start_test(cc_names[cc]);
            x = rand8();
            y = rand8();
            if (y[0]) y = x;                  // Equal operands half the time
            target = {8'h02, rand8()};
            m = alu_model(3'd7, x, y, 4'h0);
            case (cc)
                0: taken = ~m[11];
                1: taken = m[11];
                2: taken = ~m[8];
                default: taken = m[8];
            endcase
            emit_instr(OP_LD_A_D8, 2, {8'h00, x});
            emit_instr(OP_ALU_D8_MATCH | 8'h38, 2, {8'h00, y});   // CP d8
            emit_instr(cc_ops[cc], 3, target);
            emit_instr(OP_LDH_A8_A, 2, 16'h0022);
            emit(OP_HALT);
            load_ptr = target;
            emit_instr(OP_LDH_A8_A, 2, 16'h0011);
            emit(OP_HALT);
            run_program();
            check_write(taken ? 16'hFF11 : 16'hFF22, x);
            check_value("target fetched", {15'd0, taken}, {15'd0, was_fetched(target)});
            finish_test();
        end

        start_test("jp_halt");
        x = rand8();
        target = {8'h03, rand8()};
        emit_instr(OP_LD_A_D8, 2, {8'h00, x});
        emit_instr(OP_JP, 3, target);
        emit_instr(OP_LDH_A8_A, 2, 16'h0033);
        emit(OP_HALT);
        load_ptr = target;
        emit_instr(OP_LDH_A8_A, 2, 16'h0044);
        emit(OP_HALT);
        run_program();
        check_write(16'hFF44, x);
        check_value("target fetched", 16'd1, {15'd0, was_fetched(target)});
        repeat (20) @(posedge clk);
        check_value("rd pulses after HALT", 16'd0, 16'(halt_rd_rises));
        check_value("done after HALT", 16'd1, {15'd0, done});
        finish_test();

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/gb_cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module gb_cpu_assert (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        rd,
    input wire logic        wr,
    input wire logic        done,
    input wire logic [15:0] a
);

    ////////////////////////////////////////////////////////////
    // Bus strobe protocol
    ////////////////////////////////////////////////////////////

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst) !(rd && wr))
        else $error("rd and wr high in the same clock");

    // Write strobe lasts the T_DATA clock only
    wr_one_clock: assert property (@(posedge clk) disable iff (rst) $rose(wr) |=> !wr)
        else $error("wr held longer than one clock");

    addr_stable: assert property (@(posedge clk) disable iff (rst)
                                  (rd && $past(rd)) |-> $stable(a))
        else $error("address moved while rd was high");

    // Halted core starts no more bus cycles
    no_rd_after_done: assert property (@(posedge clk) disable iff (rst) done |-> !$rose(rd))
        else $error("rd rose after done");

endmodule

bind gb_cpu_top gb_cpu_assert i_gb_cpu_assert (
    .clk  (clk),
    .rst  (rst),
    .rd   (rd),
    .wr   (wr),
    .done (done),
    .a    (a)
);

`default_nettype wire

//--- src/gb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module gb_cpu_top
    import gb_bus_pkg::*;
    import gb_isa_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [7:0] din,
    output logic [15:0]     a,
    output logic [7:0]      dout,
    output logic            rd,
    output logic            wr,
    output logic            phi,
    output logic            done
);

    ctrl_t       ctrl;
    t_state_t    t_state;
    logic [7:0]  opcode;
    logic [15:0] imm;
    logic [7:0]  acc;
    logic [15:0] pc;
    flags_t      flags;

    ////////////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////////////

    bus_cycle_seq i_bus_cycle_seq (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ctrl),
        .din     (din),
        .pc      (pc),
        .acc     (acc),
        .t_state (t_state),
        .a       (a),
        .dout    (dout),
        .rd      (rd),
        .wr      (wr),
        .phi     (phi),
        .done    (done),
        .opcode  (opcode),
        .imm     (imm)
    );

    // Decoder and datapath
    instr_decode i_instr_decode (
        .clk     (clk),
        .rst     (rst),
        .t_state (t_state),
        .opcode  (opcode),
        .flags   (flags),
        .ctrl    (ctrl)
    );

    cpu_regs i_cpu_regs (
        .clk     (clk),
        .rst     (rst),
        .t_state (t_state),
        .ctrl    (ctrl),
        .imm     (imm),
        .acc     (acc),
        .flags   (flags),
        .pc      (pc)
    );

endmodule

`default_nettype wire

//--- src/cpu_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regs
    import gb_bus_pkg::*;
    import gb_isa_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire t_state_t    t_state,
    input  wire ctrl_t       ctrl,
    input  wire logic [15:0] imm,
    output logic [7:0]       acc,
    output flags_t           flags,
    output logic [15:0]      pc
);

    logic [7:0] alu_result;
    flags_t     alu_flags;
    logic       bus_rd_cycle;

    // Operand B is always the d8 byte
    gb_alu i_gb_alu (
        .a         (acc),
        .b         (imm[7:0]),
        .op        (ctrl.alu_op),
        .flags_in  (flags),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    assign bus_rd_cycle = (ctrl.bus_op == BUS_FETCH) || (ctrl.bus_op == BUS_READ);

    ////////////////////////////////////////////////////////////
    // A and F, updated alongside the next fetch
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc   <= 8'h00;
            flags <= '0;
        end else if (t_state == T_ADDR) begin
            case (ctrl.acc_src)
                ACC_IMM: acc <= imm[7:0];
                ACC_ALU: acc <= alu_result;
                default: acc <= acc;     // ACC_KEEP
            endcase
            if (ctrl.flags_we) begin
                flags <= alu_flags;
            end
        end
    end

    // Program counter with its own incrementer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if ((t_state == T_WAIT) && ctrl.pc_inc && bus_rd_cycle) begin
            pc <= pc + 16'd1;
        end else if ((t_state == T_IDLE) && ctrl.pc_load) begin
            pc <= imm;                   // Jump target
        end
    end

endmodule

`default_nettype wire

//--- src/bus_cycle_seq.sv
`timescale 1ns/1ps
`default_nettype none

module bus_cycle_seq
    import gb_bus_pkg::*;
    import gb_isa_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire ctrl_t       ctrl,
    input  wire logic [7:0]  din,
    input  wire logic [15:0] pc,
    input  wire logic [7:0]  acc,
    output t_state_t         t_state,
    output logic [15:0]      a,
    output logic [7:0]       dout,
    output logic             rd,
    output logic             wr,
    output logic             phi,
    output logic             done,
    output logic [7:0]       opcode,
    output logic [15:0]      imm
);

    logic [15:0] bus_addr;
    logic        imm_hi;    // Next read fills the high byte

    always_comb begin
        if (ctrl.addr_src == ADDR_IMM) begin
            bus_addr = ctrl.high_mask ? {HIGH_PAGE, imm[7:0]} : imm;
        end else begin
            bus_addr = pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // T-cycle counter and bus strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            t_state <= T_ADDR;
            a       <= 16'h0000;
            dout    <= 8'h00;
            rd      <= 1'b0;
            wr      <= 1'b0;
            phi     <= 1'b1;
            done    <= 1'b0;
            opcode  <= OP_NOP;
            imm_hi  <= 1'b0;
        end else begin
            case (t_state)
                T_ADDR: begin
                    phi <= 1'b1;
                    wr  <= 1'b0;
                    if (ctrl.halt) begin
                        done <= 1'b1;   // Stay here for good
                        rd   <= 1'b0;
                    end else begin
                        a       <= bus_addr;
                        rd      <= (ctrl.bus_op == BUS_FETCH) || (ctrl.bus_op == BUS_READ);
                        t_state <= T_WAIT;
                    end
                end
                T_WAIT: t_state <= T_DATA;
                T_DATA: begin
                    case (ctrl.bus_op)
                        BUS_WRITE: begin
                            wr   <= 1'b1;
                            dout <= acc;
                        end
                        BUS_FETCH: begin
                            opcode <= din;
                            imm_hi <= 1'b0;
                        end
                        BUS_READ: imm_hi <= 1'b1;
                        default: ;
                    endcase
                    rd      <= 1'b0;
                    phi     <= 1'b0;
                    t_state <= T_IDLE;
                end
                default: begin
                    rd      <= 1'b0;
                    wr      <= 1'b0;
                    dout    <= 8'h00;
                    t_state <= T_ADDR;
                end
            endcase
        end
    end

    // Immediate bytes, little endian across the reads of one instruction
    always_ff @(posedge clk) begin
        if ((t_state == T_DATA) && (ctrl.bus_op == BUS_READ)) begin
            if (imm_hi) begin
                imm[15:8] <= din;
            end else begin
                imm[7:0] <= din;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import gb_bus_pkg::*;
    import gb_isa_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire t_state_t t_state,
    input  wire logic [7:0] opcode,
    input  wire flags_t   flags,
    output ctrl_t         ctrl
);

    logic [1:0] m_cycle;
    logic       is_ld;
    logic       is_alu;
    logic       is_ldh;
    logic       is_jp;
    logic       is_jp_cc;
    logic       multi;
    logic       cc_flag;
    logic       cond_ok;

    ////////////////////////////////////////////////////////////
    // Opcode classes
    ////////////////////////////////////////////////////////////

    assign is_ld    = (opcode == OP_LD_A_D8);
    assign is_alu   = ((opcode & OP_ALU_D8_MASK) == OP_ALU_D8_MATCH);
    assign is_ldh   = (opcode == OP_LDH_A8_A);
    assign is_jp    = (opcode == OP_JP);
    assign is_jp_cc = (opcode == OP_JP_NZ) || (opcode == OP_JP_Z) ||
                      (opcode == OP_JP_NC) || (opcode == OP_JP_C);
    assign multi    = is_ld | is_alu | is_ldh | is_jp | is_jp_cc;

    // Bit 4 picks C over Z, bit 3 picks set over clear
    assign cc_flag = opcode[4] ? flags.c : flags.z;
    assign cond_ok = opcode[3] ? cc_flag : ~cc_flag;

    // Machine cycle counter, steps at the end of each bus cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_cycle <= 2'd0;
        end else if (t_state == T_IDLE) begin
            m_cycle <= ctrl.last ? 2'd0 : m_cycle + 2'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Control word per machine cycle
    ////////////////////////////////////////////////////////////

    always_comb begin
        ctrl          = '0;
        ctrl.bus_op   = BUS_NONE;
        ctrl.addr_src = ADDR_PC;
        ctrl.acc_src  = ACC_KEEP;
        ctrl.alu_op   = alu_op_t'(opcode[5:3]);

        case (m_cycle)
            2'd0: begin
                // Opcode still holds the finished instruction until T_DATA
                if (opcode == OP_HALT) begin
                    ctrl.halt = 1'b1;
                    ctrl.last = 1'b1;
                end else begin
                    ctrl.bus_op = BUS_FETCH;
                    ctrl.pc_inc = 1'b1;
                    ctrl.last   = ~multi;  // Seen with the new opcode at T_IDLE
                end
                if (is_ld) begin
                    ctrl.acc_src = ACC_IMM;
                end
                if (is_alu) begin
                    ctrl.flags_we = 1'b1;
                    if (ctrl.alu_op != ALU_CP) begin
                        ctrl.acc_src = ACC_ALU;
                    end
                end
            end
            2'd1: begin
                ctrl.bus_op = BUS_READ;           // d8, a8 or target low
                ctrl.pc_inc = 1'b1;
                ctrl.last   = is_ld | is_alu | ~multi;
            end
            2'd2: begin
                if (is_ldh) begin
                    ctrl.bus_op    = BUS_WRITE;
                    ctrl.addr_src  = ADDR_IMM;
                    ctrl.high_mask = 1'b1;
                    ctrl.last      = 1'b1;
                end else if (is_jp | is_jp_cc) begin
                    ctrl.bus_op = BUS_READ;       // Target high
                    ctrl.pc_inc = 1'b1;
                    ctrl.last   = is_jp_cc & ~cond_ok;
                end else begin
                    ctrl.last = 1'b1;
                end
            end
            default: begin
                ctrl.pc_load = is_jp | is_jp_cc;  // Idle bus, PC takes target
                ctrl.last    = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/gb_alu.sv
`timescale 1ns/1ps
`default_nettype none

module gb_alu
    import gb_isa_pkg::*;
(
    input  wire logic [7:0] a,
    input  wire logic [7:0] b,
    input  wire alu_op_t    op,
    input  wire flags_t     flags_in,
    output logic [7:0]      result,
    output flags_t          flags_out
);

    logic       cin;
    logic [4:0] sum_lo;
    logic [8:0] sum;
    logic [4:0] dif_lo;
    logic [8:0] dif;

    // Only the carry forms take the incoming C
    assign cin = ((op == ALU_ADC) || (op == ALU_SBC)) ? flags_in.c : 1'b0;

    // Nibble sums give H, full sums give C
    assign sum_lo = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, cin};
    assign sum    = {1'b0, a} + {1'b0, b} + {8'b0, cin};
    assign dif_lo = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'b0, cin};
    assign dif    = {1'b0, a} - {1'b0, b} - {8'b0, cin};

    always_comb begin
        result      = a;
        flags_out   = '0;
        case (op)
            ALU_ADD, ALU_ADC: begin
                result      = sum[7:0];
                flags_out.h = sum_lo[4];
                flags_out.c = sum[8];
            end
            ALU_SUB, ALU_SBC: begin
                result      = dif[7:0];
                flags_out.n = 1'b1;
                flags_out.h = dif_lo[4];  // Borrow out of bit 3
                flags_out.c = dif[8];
            end
            ALU_CP: begin
                result      = a;          // Compare leaves A alone
                flags_out.n = 1'b1;
                flags_out.h = dif_lo[4];
                flags_out.c = dif[8];
            end
            ALU_AND: begin
                result      = a & b;
                flags_out.h = 1'b1;
            end
            ALU_XOR: result = a ^ b;
            ALU_OR:  result = a | b;
            default: result = a;
        endcase

        // Z of a compare comes from the difference, not the result
        if (op == ALU_CP) begin
            flags_out.z = (dif[7:0] == 8'h00);
        end else begin
            flags_out.z = (result == 8'h00);
        end
    end

endmodule

`default_nettype wire

//--- src/gb_isa_pkg.sv
`default_nettype none

package gb_isa_pkg;

    import gb_bus_pkg::*;

    ////////////////////////////////////////////////////////////
    // Opcodes of the supported subset
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] OP_NOP      = 8'h00;
    localparam logic [7:0] OP_LD_A_D8  = 8'h3E;
    localparam logic [7:0] OP_LDH_A8_A = 8'hE0;
    localparam logic [7:0] OP_JP       = 8'hC3;
    localparam logic [7:0] OP_JP_NZ    = 8'hC2;
    localparam logic [7:0] OP_JP_Z     = 8'hCA;
    localparam logic [7:0] OP_JP_NC    = 8'hD2;
    localparam logic [7:0] OP_JP_C     = 8'hDA;
    localparam logic [7:0] OP_HALT     = 8'h76;

    // ALU A,d8 group is 11xxx110, operation in bits 5..3
    localparam logic [7:0] OP_ALU_D8_MASK  = 8'hC7;
    localparam logic [7:0] OP_ALU_D8_MATCH = 8'hC6;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_ADC = 3'd1,
        ALU_SUB = 3'd2,
        ALU_SBC = 3'd3,
        ALU_AND = 3'd4,
        ALU_XOR = 3'd5,
        ALU_OR  = 3'd6,
        ALU_CP  = 3'd7
    } alu_op_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    typedef enum logic [1:0] {
        ACC_KEEP = 2'd0,
        ACC_IMM  = 2'd1,
        ACC_ALU  = 2'd2
    } acc_src_t;

    ////////////////////////////////////////////////////////////
    // Control word, one per machine cycle
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        bus_op_t   bus_op;
        addr_src_t addr_src;
        logic      high_mask;  // Address becomes FF00 + imm low
        logic      pc_inc;
        logic      pc_load;
        acc_src_t  acc_src;
        logic      flags_we;
        alu_op_t   alu_op;
        logic      last;       // Final machine cycle of the instruction
        logic      halt;
    } ctrl_t;

endpackage

`default_nettype wire

//--- src/gb_bus_pkg.sv
`default_nettype none

package gb_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Machine cycle timing
    ////////////////////////////////////////////////////////////

    // Four clocks per machine cycle
    typedef enum logic [1:0] {
        T_ADDR = 2'd0,  // Address out, rd up, phi up
        T_WAIT = 2'd1,  // Memory access time
        T_DATA = 2'd2,  // Sample din, drive write data
        T_IDLE = 2'd3   // Strobes released
    } t_state_t;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_FETCH = 2'd1,
        BUS_WRITE = 2'd2,
        BUS_READ  = 2'd3
    } bus_op_t;

    typedef enum logic {
        ADDR_PC  = 1'b0,
        ADDR_IMM = 1'b1
    } addr_src_t;

    ////////////////////////////////////////////////////////////
    // Address constants
    ////////////////////////////////////////////////////////////

    localparam logic [7:0]  HIGH_PAGE = 8'hFF;   // LDH upper byte
    localparam logic [15:0] RESET_PC  = 16'h0000;

endpackage

`default_nettype wire
